//--- src/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// bus geometry
`define SOC_DATA_W          32
`define SOC_SLAVE_W         2
`define SOC_REG_W           3
`define SOC_ADDR_W          (`SOC_SLAVE_W + `SOC_REG_W)

// interrupt sources
`define SOC_EXT_INT_NUM     3
`define SOC_INT_NUM         (`SOC_EXT_INT_NUM + 1)   // timer line on top

// ext_int_ctrl register map
`define SOC_EXT_ENABLE      0
`define SOC_EXT_STATUS      1
`define SOC_EXT_RAW         2

// irq_timer register map
`define SOC_TMR_CTRL        0
`define SOC_TMR_COMPARE     1
`define SOC_TMR_COUNT       2
`define SOC_TMR_STATUS      3

// int_ctrl register map
`define SOC_IC_MASK         0
`define SOC_IC_PENDING      1
`define SOC_IC_GLOBAL       2

// timer control bits
`define SOC_TMR_EN_BIT      0
`define SOC_TMR_IRQ_EN_BIT  1
`define SOC_TMR_CONT_BIT    2

`endif

//--- src/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

	// one bus word
	typedef logic [`SOC_DATA_W-1:0] data_t;

	// register offset within a single slave
	typedef logic [`SOC_REG_W-1:0] reg_off_t;

	typedef enum logic [`SOC_SLAVE_W-1:0] {
		SLV_EXT_INT  = 2'd0,
		SLV_TIMER    = 2'd1,
		SLV_INT_CTRL = 2'd2,
		SLV_NONE     = 2'd3   // unmapped, reads zero
	} slave_sel_e;

	// slave field sits above the register field
	typedef struct packed {
		slave_sel_e slave;
		reg_off_t   off;
	} soc_addr_t;

	// fabric decodes the struct view, peripherals take the low bits of raw
	typedef union packed {
		logic [`SOC_ADDR_W-1:0] raw;
		soc_addr_t              fields;
	} soc_addr_u;

	// one bit per external input
	typedef logic [`SOC_EXT_INT_NUM-1:0] ext_vec_t;

	// controller inputs, timer in the msb
	typedef logic [`SOC_INT_NUM-1:0] int_vec_t;

endpackage

//--- src/periph_bus.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module periph_bus (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  soc_pkg::soc_addr_u adr_i,
	input  soc_pkg::data_t     dat_i,
	output logic               ack_o,
	output soc_pkg::data_t     dat_o,
	output soc_pkg::reg_off_t  reg_off_o,
	output soc_pkg::data_t     wdata_o,
	output logic               ext_wr_o,
	output logic               tmr_wr_o,
	output logic               ic_wr_o,
	input  soc_pkg::data_t     ext_rdata_i,
	input  soc_pkg::data_t     tmr_rdata_i,
	input  soc_pkg::data_t     ic_rdata_i
);
	import soc_pkg::*;

	logic  access;
	data_t rdata_mux;

	assign access    = stb_i && !ack_o;              // new request, not yet acked
	assign reg_off_o = adr_i.raw[`SOC_REG_W-1:0];    // register view of the address
	assign wdata_o   = dat_i;

	// slave decode on the struct view
	always_comb begin
		ext_wr_o  = 1'b0;
		tmr_wr_o  = 1'b0;
		ic_wr_o   = 1'b0;
		rdata_mux = '0;
		case (adr_i.fields.slave)
			SLV_EXT_INT: begin
				ext_wr_o  = access && we_i;
				rdata_mux = ext_rdata_i;
			end
			SLV_TIMER: begin
				tmr_wr_o  = access && we_i;
				rdata_mux = tmr_rdata_i;
			end
			SLV_INT_CTRL: begin
				ic_wr_o   = access && we_i;
				rdata_mux = ic_rdata_i;
			end
			default: rdata_mux = '0;   // unmapped range
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= access;                        // single-cycle pulse
			if (access && !we_i)
				dat_o <= rdata_mux;                 // valid with the ack
		end
	end

endmodule

//--- src/ext_int_ctrl.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module ext_int_ctrl (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              wr_i,
	input  soc_pkg::reg_off_t reg_off_i,
	input  soc_pkg::data_t    wdata_i,
	output soc_pkg::data_t    rdata_o,
	input  soc_pkg::ext_vec_t ext_int_i,
	output soc_pkg::ext_vec_t pending_o
);
	import soc_pkg::*;

	ext_vec_t sync1;
	ext_vec_t sync2;
	ext_vec_t edge_q;
	ext_vec_t enable_reg;
	ext_vec_t pending_reg;
	ext_vec_t rise;
	ext_vec_t clr;

	assign rise = sync2 & ~edge_q;   // rising edge of the synchronized level

	// write-one-to-clear on STATUS
	assign clr = (wr_i && reg_off_i == `SOC_EXT_STATUS) ?
		wdata_i[`SOC_EXT_INT_NUM-1:0] : '0;

	// two-flop synchronizer plus edge register
	always_ff @(posedge clk) begin
		if (reset_i) begin
			sync1  <= '0;
			sync2  <= '0;
			edge_q <= '0;
		end else begin
			sync1  <= ext_int_i;
			sync2  <= sync1;
			edge_q <= sync2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			enable_reg  <= '0;
			pending_reg <= '0;
		end else begin
			if (wr_i && reg_off_i == `SOC_EXT_ENABLE)
				enable_reg <= wdata_i[`SOC_EXT_INT_NUM-1:0];
			// a new edge beats a clear in the same cycle
			pending_reg <= (pending_reg & ~clr) | (rise & enable_reg);
		end
	end

	always_comb begin
		case (reg_off_i)
			`SOC_EXT_ENABLE: rdata_o = data_t'(enable_reg);
			`SOC_EXT_STATUS: rdata_o = data_t'(pending_reg);
			`SOC_EXT_RAW:    rdata_o = data_t'(sync2);   // synchronized levels
			default:         rdata_o = '0;
		endcase
	end

	assign pending_o = pending_reg;

endmodule

//--- src/irq_timer.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module irq_timer (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              wr_i,
	input  soc_pkg::reg_off_t reg_off_i,
	input  soc_pkg::data_t    wdata_i,
	output soc_pkg::data_t    rdata_o,
	output logic              irq_o
);
	import soc_pkg::*;

	logic [`SOC_TMR_CONT_BIT:0] ctrl_reg;   // cont, irq_en, en
	data_t                      compare_reg;
	data_t                      count_reg;
	logic                       flag_reg;
	logic                       match;
	logic                       wr_ctrl;
	logic                       wr_cmp;
	logic                       wr_cnt;
	logic                       wr_stat;

	assign wr_ctrl = wr_i && reg_off_i == `SOC_TMR_CTRL;
	assign wr_cmp  = wr_i && reg_off_i == `SOC_TMR_COMPARE;
	assign wr_cnt  = wr_i && reg_off_i == `SOC_TMR_COUNT;
	assign wr_stat = wr_i && reg_off_i == `SOC_TMR_STATUS;

	// count reached compare while running
	assign match = ctrl_reg[`SOC_TMR_EN_BIT] && (count_reg == compare_reg);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ctrl_reg    <= '0;
			compare_reg <= '0;
			count_reg   <= '0;
			flag_reg    <= 1'b0;
		end else begin
			// control, one-shot stops itself on match
			if (wr_ctrl)
				ctrl_reg <= wdata_i[`SOC_TMR_CONT_BIT:0];
			else if (match && !ctrl_reg[`SOC_TMR_CONT_BIT])
				ctrl_reg[`SOC_TMR_EN_BIT] <= 1'b0;

			if (wr_cmp)
				compare_reg <= wdata_i;

			// counter, a software load has priority
			if (wr_cnt)
				count_reg <= wdata_i;
			else if (match)
				count_reg <= '0;
			else if (ctrl_reg[`SOC_TMR_EN_BIT])
				count_reg <= count_reg + 1'b1;

			// match flag, set wins over clear
			if (match)
				flag_reg <= 1'b1;
			else if (wr_stat && wdata_i[0])
				flag_reg <= 1'b0;
		end
	end

	always_comb begin
		case (reg_off_i)
			`SOC_TMR_CTRL:    rdata_o = data_t'(ctrl_reg);
			`SOC_TMR_COMPARE: rdata_o = compare_reg;
			`SOC_TMR_COUNT:   rdata_o = count_reg;
			`SOC_TMR_STATUS:  rdata_o = data_t'(flag_reg);
			default:          rdata_o = '0;
		endcase
	end

	assign irq_o = flag_reg && ctrl_reg[`SOC_TMR_IRQ_EN_BIT];

endmodule

//--- src/int_ctrl.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module int_ctrl (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              wr_i,
	input  soc_pkg::reg_off_t reg_off_i,
	input  soc_pkg::data_t    wdata_i,
	output soc_pkg::data_t    rdata_o,
	input  soc_pkg::int_vec_t int_i,
	output logic              int_o
);
	import soc_pkg::*;

	int_vec_t mask_reg;
	logic     global_en;
	int_vec_t masked;

	// requests are level, cleared at their source
	assign masked = int_i & mask_reg;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mask_reg  <= '0;
			global_en <= 1'b0;
		end else if (wr_i) begin
			case (reg_off_i)
				`SOC_IC_MASK:   mask_reg  <= wdata_i[`SOC_INT_NUM-1:0];
				`SOC_IC_GLOBAL: global_en <= wdata_i[0];
				default:        ;   // PENDING is read only
			endcase
		end
	end

	// one register stage to the system line
	always_ff @(posedge clk) begin
		if (reset_i)
			int_o <= 1'b0;
		else
			int_o <= global_en && (|masked);
	end

	always_comb begin
		case (reg_off_i)
			`SOC_IC_MASK:    rdata_o = data_t'(mask_reg);
			`SOC_IC_PENDING: rdata_o = data_t'(masked);
			`SOC_IC_GLOBAL:  rdata_o = data_t'(global_en);
			default:         rdata_o = '0;
		endcase
	end

endmodule

//--- src/intc_soc.sv
`timescale 1ns/1ps
module intc_soc (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               cpu_stb_i,
	input  logic               cpu_we_i,
	input  soc_pkg::soc_addr_u cpu_adr_i,
	input  soc_pkg::data_t     cpu_dat_i,
	output logic               cpu_ack_o,
	output soc_pkg::data_t     cpu_dat_o,
	input  soc_pkg::ext_vec_t  ext_int_i,
	output logic               sys_int_o
);
	import soc_pkg::*;

	reg_off_t reg_off;
	data_t    wdata;
	logic     ext_wr;
	logic     tmr_wr;
	logic     ic_wr;
	data_t    ext_rdata;
	data_t    tmr_rdata;
	data_t    ic_rdata;
	ext_vec_t ext_pending;   // latched external requests
	logic     tmr_irq;

	periph_bus the_bus (
		.clk         (clk),
		.reset_i     (reset_i),
		.stb_i       (cpu_stb_i),
		.we_i        (cpu_we_i),
		.adr_i       (cpu_adr_i),
		.dat_i       (cpu_dat_i),
		.ack_o       (cpu_ack_o),
		.dat_o       (cpu_dat_o),
		.reg_off_o   (reg_off),
		.wdata_o     (wdata),
		.ext_wr_o    (ext_wr),
		.tmr_wr_o    (tmr_wr),
		.ic_wr_o     (ic_wr),
		.ext_rdata_i (ext_rdata),
		.tmr_rdata_i (tmr_rdata),
		.ic_rdata_i  (ic_rdata)
	);

	ext_int_ctrl the_ext_int (
		.clk       (clk),
		.reset_i   (reset_i),
		.wr_i      (ext_wr),
		.reg_off_i (reg_off),
		.wdata_i   (wdata),
		.rdata_o   (ext_rdata),
		.ext_int_i (ext_int_i),
		.pending_o (ext_pending)
	);

	irq_timer the_timer (
		.clk       (clk),
		.reset_i   (reset_i),
		.wr_i      (tmr_wr),
		.reg_off_i (reg_off),
		.wdata_i   (wdata),
		.rdata_o   (tmr_rdata),
		.irq_o     (tmr_irq)
	);

	int_ctrl the_int_ctrl (
		.clk       (clk),
		.reset_i   (reset_i),
		.wr_i      (ic_wr),
		.reg_off_i (reg_off),
		.wdata_i   (wdata),
		.rdata_o   (ic_rdata),
		.int_i     ({tmr_irq, ext_pending}),   // timer in the msb
		.int_o     (sys_int_o)
	);

endmodule

//--- testbench/intc_soc_props.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module intc_soc_props (
	input logic              clk,
	input logic              reset_i,
	input logic              stb_i,
	input logic              ack_i,
	input logic              sys_int_i,
	input soc_pkg::ext_vec_t ext_int_i,
	input soc_pkg::ext_vec_t ext_en_i,
	input soc_pkg::int_vec_t ic_mask_i,
	input logic              ic_global_i
);
	import soc_pkg::*;

	int unsigned fail_cnt = 0;   // read by the testbench at the end

	ack_pulse: assert property (@(posedge clk) disable iff (reset_i) ack_i |=> !ack_i)
		else begin
			$error("cpu_ack_o stayed high for more than one cycle");
			fail_cnt++;
		end

	ack_after_stb: assert property (@(posedge clk) disable iff (reset_i) ack_i |-> $past(stb_i))
		else begin
			$error("cpu_ack_o without a strobe in the cycle before");
			fail_cnt++;
		end

	int_low_in_reset: assert property (@(posedge clk) reset_i |=> !sys_int_i)
		else begin
			$error("sys_int_o high during or right after reset");
			fail_cnt++;
		end

	// enabled external edge reaches the system line
	ext_to_sys_int: assert property (@(posedge clk) disable iff (reset_i)
		(|(ext_int_i & ~$past(ext_int_i) & ext_en_i & ic_mask_i[`SOC_EXT_INT_NUM-1:0])
			&& ic_global_i) |-> ##[3:6] sys_int_i)
		else begin
			$error("enabled external edge did not raise sys_int_o in 3 to 6 cycles");
			fail_cnt++;
		end

	int_low_no_global: assert property (@(posedge clk) disable iff (reset_i)
		!ic_global_i |=> !sys_int_i)
		else begin
			$error("sys_int_o high while GLOBAL is clear");
			fail_cnt++;
		end

endmodule

bind intc_soc intc_soc_props the_props (
	.clk         (clk),
	.reset_i     (reset_i),
	.stb_i       (cpu_stb_i),
	.ack_i       (cpu_ack_o),
	.sys_int_i   (sys_int_o),
	.ext_int_i   (ext_int_i),
	.ext_en_i    (the_ext_int.enable_reg),
	.ic_mask_i   (the_int_ctrl.mask_reg),
	.ic_global_i (the_int_ctrl.global_en)
);

//--- testbench/tb_intc_soc.sv
`include "soc_cfg.svh"

`timescale 1ns/1ps
module tb_intc_soc;
	import soc_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;   // about four times the test length

	logic        clk;
	logic        reset_i;
	logic        cpu_stb;
	logic        cpu_we;
	soc_addr_u   cpu_adr;
	data_t       cpu_dat_w;
	logic        cpu_ack;
	data_t       cpu_dat_r;
	ext_vec_t    ext_int;
	logic        sys_int;
	int unsigned cycle_cnt;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;
	data_t       w;
	ext_vec_t    en;
	ext_vec_t    exp_pend;
	int          order [3];
	int          elapsed;
	int          c;

	intc_soc DUT (
		.clk       (clk),
		.reset_i   (reset_i),
		.cpu_stb_i (cpu_stb),
		.cpu_we_i  (cpu_we),
		.cpu_adr_i (cpu_adr),
		.cpu_dat_i (cpu_dat_w),
		.cpu_ack_o (cpu_ack),
		.cpu_dat_o (cpu_dat_r),
		.ext_int_i (ext_int),
		.sys_int_o (sys_int)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;   // back to the drive point
	endtask

	task automatic bus_access(input logic we, input slave_sel_e s, input int off,
			input data_t d, output data_t q);
		cpu_stb             = 1'b1;
		cpu_we              = we;
		cpu_adr.fields.slave = s;
		cpu_adr.fields.off   = reg_off_t'(off);
		cpu_dat_w           = d;
		do
			wait_cycles(1);
		while (!cpu_ack);
		q       = cpu_dat_r;   // valid in the ack cycle
		cpu_stb = 1'b0;
	endtask

	task automatic bus_write(input slave_sel_e s, input int off, input data_t d);
		data_t q;
		bus_access(1'b1, s, off, d, q);
	endtask

	task automatic bus_read(input slave_sel_e s, input int off, output data_t q);
		bus_access(1'b0, s, off, '0, q);
	endtask

	task automatic check_reg(input string name, input slave_sel_e s, input int off,
			input data_t exp);
		data_t q;
		bus_read(s, off, q);
		assert (q === exp)
		else begin
			$display("FAILED %0t %s expected %h actual %h", $time, name, exp, q);
			test_errors++;
		end
	endtask

	task automatic check_int(input logic exp);
		assert (sys_int === exp)
		else begin
			$display("FAILED %0t sys_int_o expected %b actual %b", $time, exp, sys_int);
			test_errors++;
		end
	endtask

	// polls the timer flag, returns the cycles spent
	task automatic wait_timer_flag(input int limit, output int cycles);
		int unsigned start;
		data_t       q;
		start = cycle_cnt;
		do
			bus_read(SLV_TIMER, `SOC_TMR_STATUS, q);
		while (q[0] !== 1'b1 && cycle_cnt - start < limit);
		cycles = cycle_cnt - start;
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		reset_i      = 1'b1;
		cpu_stb      = 1'b0;
		cpu_we       = 1'b0;
		cpu_adr      = '0;
		cpu_dat_w    = '0;
		ext_int      = '0;
		cycle_cnt    = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(34577));
		wait_cycles(2);
		reset_i = 1'b0;

		for (int i = 0; i < 2; i++)
			check_reg($sformatf("ext reg %0d", i), SLV_EXT_INT, i, '0);
		check_reg("ext RAW", SLV_EXT_INT, `SOC_EXT_RAW, data_t'(ext_int));
		for (int i = 0; i < 4; i++)
			check_reg($sformatf("timer reg %0d", i), SLV_TIMER, i, '0);
		for (int i = 0; i < 3; i++)
			check_reg($sformatf("int_ctrl reg %0d", i), SLV_INT_CTRL, i, '0);
		w = $urandom;
		bus_write(SLV_EXT_INT, `SOC_EXT_ENABLE, w);
		check_reg("ext ENABLE", SLV_EXT_INT, `SOC_EXT_ENABLE, w & ((1 << `SOC_EXT_INT_NUM) - 1));
		w = $urandom;
		bus_write(SLV_TIMER, `SOC_TMR_COMPARE, w);
		check_reg("timer COMPARE", SLV_TIMER, `SOC_TMR_COMPARE, w);
		w = $urandom;
		bus_write(SLV_INT_CTRL, `SOC_IC_MASK, w);
		check_reg("ic MASK", SLV_INT_CTRL, `SOC_IC_MASK, w & ((1 << `SOC_INT_NUM) - 1));
		w = $urandom;
		bus_write(SLV_INT_CTRL, `SOC_IC_GLOBAL, w);
		check_reg("ic GLOBAL", SLV_INT_CTRL, `SOC_IC_GLOBAL, w & 1);
		bus_write(SLV_EXT_INT, `SOC_EXT_ENABLE, 0);
		bus_write(SLV_INT_CTRL, `SOC_IC_MASK, 0);
		bus_write(SLV_INT_CTRL, `SOC_IC_GLOBAL, 0);
		for (int i = 0; i < 8; i++)
			bus_write(SLV_NONE, i, '1);   // unmapped, ignored
		for (int i = 0; i < 8; i++)
			check_reg($sformatf("unmapped reg %0d", i), SLV_NONE, i, '0);
		check_reg("ext ENABLE", SLV_EXT_INT, `SOC_EXT_ENABLE, '0);
		check_reg("timer CTRL", SLV_TIMER, `SOC_TMR_CTRL, '0);
		check_reg("ic MASK", SLV_INT_CTRL, `SOC_IC_MASK, '0);
		check_reg("ic GLOBAL", SLV_INT_CTRL, `SOC_IC_GLOBAL, '0);
		finish_test("registers after reset");

		en = ext_vec_t'($urandom_range(6, 1));   // at least one on, one off
		bus_write(SLV_EXT_INT, `SOC_EXT_ENABLE, data_t'(en));
		order = '{0, 1, 2};
		for (int i = 2; i > 0; i--) begin
			c = $urandom_range(i, 0);
			{order[i], order[c]} = {order[c], order[i]};
		end
		exp_pend = '0;
		foreach (order[i]) begin
			ext_int[order[i]]  = 1'b1;
			exp_pend[order[i]] = en[order[i]];
			wait_cycles(4);
			check_reg("ext STATUS", SLV_EXT_INT, `SOC_EXT_STATUS, data_t'(exp_pend));
		end
		check_reg("ext RAW", SLV_EXT_INT, `SOC_EXT_RAW, 32'h7);
		bus_write(SLV_EXT_INT, `SOC_EXT_STATUS, 32'h7);
		ext_int = '0;
		wait_cycles(4);
		check_reg("ext STATUS", SLV_EXT_INT, `SOC_EXT_STATUS, '0);
		bus_write(SLV_EXT_INT, `SOC_EXT_ENABLE, 0);
		finish_test("external pending capture");

		c = $urandom_range(40, 10);
		bus_write(SLV_TIMER, `SOC_TMR_COMPARE, c);
		bus_write(SLV_TIMER, `SOC_TMR_COUNT, 0);
		bus_write(SLV_TIMER, `SOC_TMR_CTRL, 1 << `SOC_TMR_EN_BIT);
		wait_timer_flag(c + 8, elapsed);
		assert (elapsed >= c + 1 && elapsed <= c + 5)
		else begin
			$display("one-shot flag came after %0d cycles, about %0d expected", elapsed, c + 1);
			test_errors++;
		end
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 1);
		check_reg("timer CTRL", SLV_TIMER, `SOC_TMR_CTRL, 0);   // enable self-cleared
		check_reg("timer COUNT", SLV_TIMER, `SOC_TMR_COUNT, 0);
		bus_write(SLV_TIMER, `SOC_TMR_STATUS, 1);
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 0);
		finish_test("one-shot timer");

		c = $urandom_range(20, 10);
		bus_write(SLV_TIMER, `SOC_TMR_COMPARE, c);
		bus_write(SLV_TIMER, `SOC_TMR_COUNT, 0);
		bus_write(SLV_TIMER, `SOC_TMR_CTRL, (1 << `SOC_TMR_EN_BIT) | (1 << `SOC_TMR_CONT_BIT));
		wait_timer_flag(c + 8, elapsed);
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 1);
		bus_write(SLV_TIMER, `SOC_TMR_STATUS, 1);
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 0);
		wait_timer_flag(c + 8, elapsed);
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 1);
		check_reg("timer CTRL", SLV_TIMER, `SOC_TMR_CTRL,
			(1 << `SOC_TMR_EN_BIT) | (1 << `SOC_TMR_CONT_BIT));
		bus_write(SLV_TIMER, `SOC_TMR_CTRL, 0);
		bus_write(SLV_TIMER, `SOC_TMR_STATUS, 1);
		check_reg("timer STATUS", SLV_TIMER, `SOC_TMR_STATUS, 0);
		finish_test("continuous timer");

		bus_write(SLV_EXT_INT, `SOC_EXT_ENABLE, 32'h7);
		bus_write(SLV_INT_CTRL, `SOC_IC_MASK, 32'h7);   // external lines only
		c = $urandom_range(2, 0);
		ext_int[c] = 1'b1;
		wait_cycles(6);
		check_int(1'b0);   // GLOBAL still clear
		check_reg("ic PENDING", SLV_INT_CTRL, `SOC_IC_PENDING, 1 << c);
		bus_write(SLV_INT_CTRL, `SOC_IC_GLOBAL, 1);
		wait_cycles(2);
		check_int(1'b1);
		bus_write(SLV_EXT_INT, `SOC_EXT_STATUS, 32'h7);
		ext_int = '0;
		wait_cycles(2);
		check_int(1'b0);
		c = $urandom_range(2, 0);
		ext_int[c] = 1'b1;   // edge with GLOBAL already set
		wait_cycles(6);
		check_int(1'b1);
		bus_write(SLV_EXT_INT, `SOC_EXT_STATUS, 32'h7);
		ext_int = '0;
		wait_cycles(2);
		check_int(1'b0);
		bus_write(SLV_INT_CTRL, `SOC_IC_MASK, 1 << `SOC_EXT_INT_NUM);   // timer line only
		c = $urandom_range(2, 0);
		ext_int[c] = 1'b1;   // pending but masked out
		bus_write(SLV_TIMER, `SOC_TMR_COMPARE, 3);
		bus_write(SLV_TIMER, `SOC_TMR_COUNT, 0);
		bus_write(SLV_TIMER, `SOC_TMR_CTRL, (1 << `SOC_TMR_EN_BIT) | (1 << `SOC_TMR_IRQ_EN_BIT));
		wait_timer_flag(12, elapsed);
		wait_cycles(2);
		check_int(1'b1);
		check_reg("ic PENDING", SLV_INT_CTRL, `SOC_IC_PENDING, 1 << `SOC_EXT_INT_NUM);
		bus_write(SLV_INT_CTRL, `SOC_IC_GLOBAL, 0);
		wait_cycles(2);
		check_int(1'b0);
		bus_write(SLV_INT_CTRL, `SOC_IC_GLOBAL, 1);
		wait_cycles(2);
		check_int(1'b1);
		bus_write(SLV_TIMER, `SOC_TMR_STATUS, 1);
		wait_cycles(2);
		check_int(1'b0);   // external request still pending
		check_reg("ic PENDING", SLV_INT_CTRL, `SOC_IC_PENDING, '0);
		bus_write(SLV_EXT_INT, `SOC_EXT_STATUS, 32'h7);
		ext_int = '0;
		finish_test("interrupt combining");

		$display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
			tests_passed, tests_failed, DUT.the_props.fail_cnt);
		if (tests_failed == 0 && DUT.the_props.fail_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- intc_soc.f
+incdir+src
src/soc_pkg.sv
src/periph_bus.sv
src/ext_int_ctrl.sv
src/irq_timer.sv
src/int_ctrl.sv
src/intc_soc.sv
testbench/intc_soc_props.sv
testbench/tb_intc_soc.sv
